//--- verilog/mem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the parity-protected DRAM board
// Word address is 20 bits and is split into 10-bit row and column halves
// Size codes follow the SIP size parameter; the disabled size is not supported
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mem_pkg;

  localparam int ADDR_W = 20;       // Word address width

  // SIP size codes
  localparam int RAM_SIZE_64K = 1;  // 65536 words
  localparam int RAM_SIZE_1M  = 2;  // 1048576 words

  // One memory request from the CPU side
  typedef struct packed {
    logic              write;    // 1 = write cycle
    logic              bad_par;  // Store inverted parity (diagnostic)
    logic [ADDR_W-1:0] addr;     // Word address
    logic [15:0]       wdata;    // Write word
  } mem_req_t;

  // Strobes and multiplexed address shared by both SIPs
  typedef struct packed {
    logic                ras_n;    // Row strobe
    logic                cas_n;    // Column strobe
    logic                w_n;      // Low for write
    logic [ADDR_W/2-1:0] address;  // Row or column
  } dram_ctl_t;

  // One nine-bit data lane
  typedef struct packed {
    logic [7:0] d8;  // Data byte
    logic       d9;  // Parity bit
  } sip_data_t;

  // Read response
  typedef struct packed {
    logic [15:0] rdata;    // Merged read word
    logic [1:0]  par_err;  // Bit 0 low byte, bit 1 high byte
  } mem_rsp_t;

endpackage

//--- verilog/sip1m9.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Nine-bit SIP DRAM model, strobes sampled on sysclk rather than used as clocks
// Row latched on RAS fall, access on CAS fall while RAS is low
// Read data appears one clock after the access; no refresh, no page mode
// Address folds to the depth chosen by RAM_SIZE; power-on contents undefined
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sip1m9 #(
  parameter int RAM_SIZE = mem_pkg::RAM_SIZE_1M  // 1 = 64K words, 2 = 1M words
) (
  input  logic               sysclk,
  input  logic               rst,
  input  mem_pkg::dram_ctl_t ctl,    // Strobes and row/column address
  input  mem_pkg::sip_data_t d,      // Write lane
  output mem_pkg::sip_data_t q,      // Gated read lane
  output logic               prd_n   // Low on odd stored parity
);

  import mem_pkg::*;

  localparam int MEM_DEPTH = (RAM_SIZE == RAM_SIZE_1M) ? 1048576 : 65536;
  localparam int AW        = $clog2(MEM_DEPTH);

  // Data byte and parity bit kept in separate arrays
  logic [7:0] mem_d8 [MEM_DEPTH];
  logic       mem_d9 [MEM_DEPTH];

  logic                ras_q;    // Strobe values seen last clock
  logic                cas_q;
  logic                rd_pend;  // Read access waiting for data
  logic [ADDR_W/2-1:0] row_q;    // Latched row
  logic [AW-1:0]       rd_addr;
  sip_data_t           q_reg;    // Registered read data

  logic                ras_fall;
  logic                cas_fall;
  logic [ADDR_W-1:0]   full_addr;
  logic [AW-1:0]       mem_addr;

  assign ras_fall  = ras_q && !ctl.ras_n;
  assign cas_fall  = cas_q && !ctl.cas_n && !ctl.ras_n;  // CAS counts only inside RAS
  assign full_addr = {row_q, ctl.address};
  assign mem_addr  = full_addr[AW-1:0];                  // Fold to array depth

  // Edge detect and read pending flag
  always_ff @(posedge sysclk) begin
    if (rst) begin
      ras_q   <= 1'b1;
      cas_q   <= 1'b1;
      rd_pend <= 1'b0;
    end else begin
      ras_q   <= ctl.ras_n;
      cas_q   <= ctl.cas_n;
      rd_pend <= cas_fall && ctl.w_n;
    end
  end

  // Row latch, array write and read
  always_ff @(posedge sysclk) begin
    if (ras_fall) begin
      row_q <= ctl.address;
    end
    if (cas_fall) begin
      if (ctl.w_n) begin
        rd_addr <= mem_addr;          // Read data follows next clock
      end else begin
        mem_d8[mem_addr] <= d.d8;
        mem_d9[mem_addr] <= d.d9;
      end
    end
    if (rd_pend) begin
      q_reg.d8 <= mem_d8[rd_addr];
      q_reg.d9 <= mem_d9[rd_addr];
    end
  end

  // Output only valid during a read with CAS low
  assign q = (!ctl.cas_n && ctl.w_n) ? q_reg : '0;

  // Even parity check over the nine gated bits
  assign prd_n = ~(^q);

  // The controller must not flip read/write in the middle of a column access
  a_wn_stable: assert property (@(posedge sysclk) disable iff (rst)
      (!ctl.cas_n && !cas_q) |-> $stable(ctl.w_n))
    else $error("sip1m9: w_n changed while cas_n low");

endmodule

//--- verilog/ras_cas_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RAS/CAS sequencer for one memory cycle per request
// req is taken only while busy is low; requests during busy are dropped
// Fixed timing with done exactly 4 clocks after the accepting edge
// No refresh, no page mode, no back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ras_cas_sequencer (
  input  logic               sysclk,
  input  logic               rst,
  input  logic               req,       // Request strobe
  input  mem_pkg::mem_req_t  req_data,
  output mem_pkg::dram_ctl_t ctl,       // Strobes to both SIPs
  output logic               wr_load,   // Parity unit takes the write word
  output logic               capture,   // Parity unit takes the read lanes
  output logic               busy,
  output logic               done
);

  import mem_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_ROW,   // RAS low, row on address
    S_COL,   // CAS low, column on address
    S_HOLD,  // SIP registers read data
    S_PRE    // Lanes captured, strobes released next
  } state_t;

  state_t            state;
  logic [ADDR_W-1:0] addr_q;  // Request address
  logic              wr_q;    // Request is a write
  logic              ras_n_q;
  logic              cas_n_q;
  logic              w_n_q;
  logic              accept;

  assign accept  = req && (state == S_IDLE);
  assign busy    = (state != S_IDLE);
  assign wr_load = accept && req_data.write;
  assign capture = (state == S_PRE) && !wr_q;  // Reads only

  // Row during the RAS step, column afterwards
  assign ctl.ras_n   = ras_n_q;
  assign ctl.cas_n   = cas_n_q;
  assign ctl.w_n     = w_n_q;
  assign ctl.address = (state == S_ROW) ? addr_q[ADDR_W-1:ADDR_W/2]
                                        : addr_q[ADDR_W/2-1:0];

  always_ff @(posedge sysclk) begin
    if (rst) begin
      state   <= S_IDLE;
      wr_q    <= 1'b0;
      ras_n_q <= 1'b1;
      cas_n_q <= 1'b1;
      w_n_q   <= 1'b1;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (accept) begin
            wr_q    <= req_data.write;
            ras_n_q <= 1'b0;        // Row strobe seen on the next edge
            state   <= S_ROW;
          end
        end
        S_ROW: begin
          cas_n_q <= 1'b0;
          w_n_q   <= !wr_q;         // Set together with CAS
          state   <= S_COL;
        end
        S_COL: begin
          state <= S_HOLD;          // SIP does the access now
        end
        S_HOLD: begin
          state <= S_PRE;
        end
        S_PRE: begin
          ras_n_q <= 1'b1;          // Precharge
          cas_n_q <= 1'b1;
          w_n_q   <= 1'b1;
          done    <= 1'b1;
          state   <= S_IDLE;
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Address is payload
  always_ff @(posedge sysclk) begin
    if (accept) begin
      addr_q <= req_data.addr;
    end
  end

  // Column strobe only inside an open row
  a_cas_in_ras: assert property (@(posedge sysclk) disable iff (rst)
      $fell(ctl.cas_n) |-> !ctl.ras_n)
    else $error("ras_cas_sequencer: cas_n fell with ras_n high");

endmodule

//--- verilog/parity_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte parity for the two SIP lanes
// Write lanes carry even parity, inverted per byte when bad_par is set
// rsp changes only on capture and holds until the next read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module parity_unit (
  input  logic               sysclk,
  input  logic               rst,
  input  logic               wr_load,   // Request cycle of a write
  input  logic               capture,   // Read lanes valid
  input  mem_pkg::mem_req_t  req_data,
  output mem_pkg::sip_data_t wlane_lo,  // To low byte SIP
  output mem_pkg::sip_data_t wlane_hi,  // To high byte SIP
  input  mem_pkg::sip_data_t rlane_lo,
  input  mem_pkg::sip_data_t rlane_hi,
  input  logic               prd_n_lo,  // Low on bad parity
  input  logic               prd_n_hi,
  output mem_pkg::mem_rsp_t  rsp
);

  import mem_pkg::*;

  logic par_lo;
  logic par_hi;

  // Even parity bit, flipped for the diagnostic write
  assign par_lo = (^req_data.wdata[7:0])  ^ req_data.bad_par;
  assign par_hi = (^req_data.wdata[15:8]) ^ req_data.bad_par;

  // Write lanes held stable through the SIP access
  always_ff @(posedge sysclk) begin
    if (wr_load) begin
      wlane_lo.d8 <= req_data.wdata[7:0];
      wlane_lo.d9 <= par_lo;
      wlane_hi.d8 <= req_data.wdata[15:8];
      wlane_hi.d9 <= par_hi;
    end
  end

  // Merge lanes into one word
  always_ff @(posedge sysclk) begin
    if (rst) begin
      rsp <= '0;
    end else if (capture) begin
      rsp.rdata   <= {rlane_hi.d8, rlane_lo.d8};
      rsp.par_err <= {!prd_n_hi, !prd_n_lo};  // Flags are active low
    end
  end

  // Write load and read capture belong to different request cycles
  a_no_overlap: assert property (@(posedge sysclk) disable iff (rst)
      !(capture && wr_load))
    else $error("parity_unit: capture and wr_load in the same cycle");

endmodule

//--- verilog/mem_board.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DRAM board top: sequencer, two nine-bit SIPs and the parity unit
// Low byte in sip_lo, high byte in sip_hi, both on the same strobes
// One request at a time; done comes 4 clocks after an accepted req
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mem_board #(
  parameter int RAM_SIZE = mem_pkg::RAM_SIZE_1M  // Passed to both SIPs
) (
  input  logic              sysclk,
  input  logic              rst,
  input  logic              req,
  input  mem_pkg::mem_req_t req_data,
  output logic              busy,
  output logic              done,
  output mem_pkg::mem_rsp_t rsp
);

  import mem_pkg::*;

  dram_ctl_t ctl;        // Shared strobes
  sip_data_t wlane_lo;
  sip_data_t wlane_hi;
  sip_data_t rlane_lo;
  sip_data_t rlane_hi;
  logic      prd_n_lo;
  logic      prd_n_hi;
  logic      wr_load;
  logic      capture;

  ras_cas_sequencer seq0 (
    .sysclk  (sysclk),
    .rst     (rst),
    .req     (req),
    .req_data(req_data),
    .ctl     (ctl),
    .wr_load (wr_load),
    .capture (capture),
    .busy    (busy),
    .done    (done)
  );

  sip1m9 #(.RAM_SIZE(RAM_SIZE)) sip_lo (
    .sysclk(sysclk), .rst(rst), .ctl(ctl), .d(wlane_lo), .q(rlane_lo), .prd_n(prd_n_lo)
  );

  sip1m9 #(.RAM_SIZE(RAM_SIZE)) sip_hi (
    .sysclk(sysclk), .rst(rst), .ctl(ctl), .d(wlane_hi), .q(rlane_hi), .prd_n(prd_n_hi)
  );

  parity_unit par0 (
    .sysclk  (sysclk),
    .rst     (rst),
    .wr_load (wr_load),
    .capture (capture),
    .req_data(req_data),
    .wlane_lo(wlane_lo),
    .wlane_hi(wlane_hi),
    .rlane_lo(rlane_lo),
    .rlane_hi(rlane_hi),
    .prd_n_lo(prd_n_lo),
    .prd_n_hi(prd_n_hi),
    .rsp     (rsp)
  );

endmodule

//--- tb/mem_board_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model for the DRAM board, included inside the testbench module
// Keeps the last word written per address and whether it went in with bad parity
// Only addresses written before may be read back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MEM_BOARD_MODEL_SVH
`define MEM_BOARD_MODEL_SVH

logic [15:0] model_mem [int];  // Last written word per address
bit          model_bad [int];  // Corruption mark, set by a bad parity write

// Record one accepted write
function automatic void model_write(input int addr, input logic [15:0] data,
                                    input logic bad);
  model_mem[addr] = data;
  model_bad[addr] = bad;  // A normal write clears the mark
endfunction

// Word a read of addr should return
function automatic logic [15:0] expect_rdata(input int addr);
  if (!model_mem.exists(addr)) begin
    $display("Model holds no word for address %0h, read of unwritten location", addr);
    return 16'hxxxx;  // Forces the compare to fail
  end
  return model_mem[addr];
endfunction

// Each stored parity bit is even parity XOR bad_par, so the nine stored
// bits of a byte have odd parity exactly when the mark is set
function automatic logic [1:0] expect_par_err(input int addr);
  if (model_bad.exists(addr) && model_bad[addr]) begin
    return 2'b11;  // Both bytes corrupted together
  end
  return 2'b00;
endfunction

`endif

//--- tb/mem_board_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the DRAM board, SIPs built at the 64K-word size
// Seeded random requests, addresses kept to the lower 16 bits
// Inputs change 1 ns after the rising edge, outputs sampled there too
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mem_board_tb;

  import mem_pkg::*;

  logic     sysclk;
  logic     rst;
  logic     req;
  mem_req_t req_data;
  logic     busy;
  logic     done;
  mem_rsp_t rsp;

  integer seed;           // $random state
  int     err_count;      // Wrong values seen
  int     timeout_count;  // Waits that gave up
  int     written[$];     // Addresses the model holds

  `include "mem_board_model.svh"

  mem_board #(.RAM_SIZE(RAM_SIZE_64K)) dut0 (
    .sysclk  (sysclk),
    .rst     (rst),
    .req     (req),
    .req_data(req_data),
    .busy    (busy),
    .done    (done),
    .rsp     (rsp)
  );

  initial begin
    sysclk = 1'b0;
    forever #5 sysclk = ~sysclk;  // 100 MHz
  end

  // Random word address inside the 64K array
  function automatic logic [19:0] rand_addr();
    logic [31:0] r;
    r = $random(seed);
    return {4'h0, r[15:0]};
  endfunction

  // Random address already known to the model
  function automatic int pick_written();
    int unsigned r;
    r = $random(seed);
    return written[r % written.size()];
  endfunction

  // One request from idle, called 1 ns after an edge; can poke a write while busy
  task automatic run_cycle(input logic wr, input logic bad, input int addr,
                           input logic [15:0] wdata, input bit poke,
                           input int poke_addr, input logic [15:0] poke_data);
    int n;            // Edges since the accepting edge
    int busy_cycles;
    bit seen;
    req      = 1'b1;
    req_data = '{write: wr, bad_par: bad, addr: addr[19:0], wdata: wdata};
    @(posedge sysclk);  // Edge 0 takes the request
    #1;
    req      = 1'b0;
    req_data = '{write: 1'b0, bad_par: 1'b0, addr: rand_addr(), wdata: 16'($random(seed))};
    n           = 0;
    busy_cycles = 0;
    seen        = 1'b0;
    while (!seen && n < 20) begin
      if (done) begin
        seen = 1'b1;
      end else begin
        if (busy) begin
          busy_cycles++;
        end
        if (poke && n == 1) begin  // Lands on edge 2, mid cycle
          req      = 1'b1;
          req_data = '{write: 1'b1, bad_par: 1'b0, addr: poke_addr[19:0], wdata: poke_data};
        end else begin
          req = 1'b0;
        end
        @(posedge sysclk);
        #1;
        n++;
      end
    end
    if (!seen) begin
      timeout_count++;
      $display("Timeout at %0t: done never came within 20 cycles of the request", $time);
    end else begin
      assert (n == 4) else begin
        err_count++;
        $display("[FAIL] %0t: done came %0d cycles after req, expected 4", $time, n);
      end
      assert (busy_cycles == 4 && !busy) else begin
        err_count++;
        $display("[FAIL] %0t: busy high for %0d cycles, expected 4", $time, busy_cycles);
      end
    end
    @(posedge sysclk);
    #1;
    assert (!done) else begin  // Single cycle pulse
      err_count++;
      $display("[FAIL] %0t: done held longer than one cycle", $time);
    end
  endtask

  // Write cycle; rsp must not move
  task automatic do_write(input int addr, input logic [15:0] data, input logic bad);
    mem_rsp_t prev;
    prev = rsp;
    run_cycle(1'b1, bad, addr, data, 1'b0, 0, 16'h0);
    model_write(addr, data, bad);
    written.push_back(addr);
    assert (rsp === prev) else begin
      err_count++;
      $display("[FAIL] %0t: rsp changed on a write to %0h", $time, addr);
    end
  endtask

  // Read cycle compared with the model; unknown bits on either side fail
  task automatic check_read(input int addr, input bit poke, input int poke_addr,
                            input logic [15:0] poke_data);
    run_cycle(1'b0, 1'b0, addr, 16'h0, poke, poke_addr, poke_data);
    assert (rsp.rdata == expect_rdata(addr)) else begin
      err_count++;
      $display("[FAIL] %0t: read %0h returned %04h, expected %04h",
               $time, addr, rsp.rdata, expect_rdata(addr));
    end
    assert (rsp.par_err === expect_par_err(addr)) else begin
      err_count++;
      $display("[FAIL] %0t: read %0h par_err %02b, expected %02b",
               $time, addr, rsp.par_err, expect_par_err(addr));
    end
  endtask

  initial begin
    int          addr;
    int          target;
    int unsigned r;
    logic [15:0] data;
    seed          = 32'ha7b85cdf;
    err_count     = 0;
    timeout_count = 0;
    rst           = 1'b1;
    req           = 1'b0;
    req_data      = '0;
    repeat (3) @(posedge sysclk);
    #1;
    rst = 1'b0;

    assert (!busy && !done && rsp === '0) else begin
      err_count++;
      $display("[FAIL] %0t: outputs not idle after reset", $time);
    end

    // Mixed random writes and reads of known addresses
    repeat (150) begin
      r = $random(seed);
      if (written.size() < 8 || r[0]) begin
        do_write(rand_addr(), 16'($random(seed)), 1'b0);
      end else begin
        check_read(pick_written(), 1'b0, 0, 16'h0);
      end
    end

    // Diagnostic bad parity, then a clean rewrite
    repeat (8) begin
      addr = rand_addr();
      data = 16'($random(seed));
      do_write(addr, data, 1'b1);
      check_read(addr, 1'b0, 0, 16'h0);
      do_write(addr, ~data, 1'b0);
      check_read(addr, 1'b0, 0, 16'h0);
    end

    // Writes pulsed during busy must be dropped
    repeat (10) begin
      target = pick_written();
      data   = expect_rdata(target) ^ 16'($random(seed) | 1);  // Always differs
      check_read(pick_written(), 1'b1, target, data);
      check_read(target, 1'b0, 0, 16'h0);
    end

    $display("Errors: %0d value mismatches, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- mem_board.f
+incdir+tb
verilog/mem_pkg.sv
verilog/sip1m9.sv
verilog/ras_cas_sequencer.sv
verilog/parity_unit.sv
verilog/mem_board.sv
tb/mem_board_tb.sv
